//--- all.f
cdc_pkg.sv
fifo_mem.sv
fifo_wr_ctrl.sv
fifo_rd_ctrl.sv
fifo_async.sv
fifo_cdc.sv
cdc_bridge.sv
cdc_bridge_properties.sv
tb_cdc_bridge.sv

//--- cdc_bridge.sv
`timescale 1ns/100ps

module cdc_bridge (
   input  logic              nreset,
   input  logic              clk_in,
   input  logic              clk_out,
   // Requests entering on clk_in
   input  logic              req_access_in,
   input  cdc_pkg::packet_t  req_packet_in,
   output logic              req_wait_out,
   // Requests leaving on clk_out
   output logic              req_access_out,
   output cdc_pkg::packet_t  req_packet_out,
   input  logic              req_wait_in,
   // Responses entering on clk_out
   input  logic              rsp_access_in,
   input  cdc_pkg::packet_t  rsp_packet_in,
   output logic              rsp_wait_out,
   // Responses leaving on clk_in
   output logic              rsp_access_out,
   output cdc_pkg::packet_t  rsp_packet_out,
   input  logic              rsp_wait_in
);

   // Request path, clk_in to clk_out
   fifo_cdc #(.DEPTH(cdc_pkg::REQ_DEPTH)) u_req_cdc (
      .nreset     (nreset),
      .clk_in     (clk_in),
      .access_in  (req_access_in),
      .packet_in  (req_packet_in),
      .wait_out   (req_wait_out),
      .clk_out    (clk_out),
      .access_out (req_access_out),
      .packet_out (req_packet_out),
      .wait_in    (req_wait_in)
   );

   // Response path, clocks swapped
   fifo_cdc #(.DEPTH(cdc_pkg::RSP_DEPTH)) u_rsp_cdc (
      .nreset     (nreset),
      .clk_in     (clk_out),
      .access_in  (rsp_access_in),
      .packet_in  (rsp_packet_in),
      .wait_out   (rsp_wait_out),
      .clk_out    (clk_in),
      .access_out (rsp_access_out),
      .packet_out (rsp_packet_out),
      .wait_in    (rsp_wait_in)
   );

endmodule

//--- cdc_bridge_properties.sv
`timescale 1ns/100ps

module cdc_cdc_props (
   input logic             nreset,
   input logic             clk_in,
   input logic             clk_out,
   input logic             access_out,
   input cdc_pkg::packet_t packet_out,
   input logic             wait_in,
   input logic             wait_out
);

   // Stalled output holds valid and data
   property hold_under_wait;
      @(posedge clk_out) disable iff (!nreset)
         (access_out && wait_in) |=> (access_out && $stable(packet_out));
   endproperty

   // No valid during reset
   property access_idle_in_reset;
      @(posedge clk_out) !nreset |-> !access_out;
   endproperty

   // Almost full cleared by reset
   property wait_idle_in_reset;
      @(posedge clk_in) !nreset |-> !wait_out;
   endproperty

   a_hold : assert property (hold_under_wait)
      else $error("access_out or packet_out changed while wait_in was high");

   a_access_rst : assert property (access_idle_in_reset)
      else $error("access_out high during reset");

   a_wait_rst : assert property (wait_idle_in_reset)
      else $error("wait_out high during reset");

endmodule

bind fifo_cdc cdc_cdc_props u_props (
   .nreset     (nreset),
   .clk_in     (clk_in),
   .clk_out    (clk_out),
   .access_out (access_out),
   .packet_out (packet_out),
   .wait_in    (wait_in),
   .wait_out   (wait_out)
);

//--- cdc_pkg.sv
package cdc_pkg;

   // Width of one mesh packet
   localparam int PACKET_W = 104;

   // Request path buffering, clk_in to clk_out
   localparam int REQ_DEPTH = 32;

   // Response path buffering, clk_out to clk_in
   localparam int RSP_DEPTH = 16;

   // Entries still free when wait_out asserts
   localparam int SLACK = 4;

   // Flops per Gray pointer synchronizer
   localparam int SYNC_STAGES = 2;

   // Access size carried in each packet
   typedef enum logic [1:0] {
      dm_byte   = 2'b00,
      dm_half   = 2'b01,
      dm_word   = 2'b10,
      dm_double = 2'b11
   } datamode_t;

   // Mesh packet, MSB first
   typedef struct packed {
      // Write when set, read request when clear
      logic        write;
      // Transfer size
      datamode_t   datamode;
      // Opaque control bits
      logic [4:0]  ctrlmode;
      // Destination address
      logic [31:0] dstaddr;
      // Write data or read return data
      logic [31:0] data;
      // Return address for responses
      logic [31:0] srcaddr;
   } packet_t;

endpackage

//--- fifo_async.sv
`timescale 1ns/100ps

module fifo_async #(
   parameter int DEPTH = cdc_pkg::REQ_DEPTH
) (
   input  logic              clk_in,
   input  logic              clk_out,
   input  logic              nreset,
   input  logic              wr_en,
   input  cdc_pkg::packet_t  din,
   input  logic              rd_en,
   output cdc_pkg::packet_t  dout,
   output logic              empty,
   output logic              prog_full
);

   localparam int AW = $clog2(DEPTH);

   logic [AW-1:0] wr_addr;
   logic [AW-1:0] rd_addr;
   // Gray pointers, the only signals crossing domains
   logic [AW:0]   wr_gray;
   logic [AW:0]   rd_gray;
   logic          full;
   logic          mem_wr;
   logic          mem_rd;

   // Storage sees only accepted operations
   assign mem_wr = wr_en & ~full;
   assign mem_rd = rd_en & ~empty;

   fifo_wr_ctrl #(.DEPTH(DEPTH)) u_wr_ctrl (
      .clk_in    (clk_in),
      .nreset    (nreset),
      .wr_en     (wr_en),
      .rd_gray   (rd_gray),
      .wr_addr   (wr_addr),
      .wr_gray   (wr_gray),
      .full      (full),
      .prog_full (prog_full)
   );

   fifo_rd_ctrl #(.DEPTH(DEPTH)) u_rd_ctrl (
      .clk_out (clk_out),
      .nreset  (nreset),
      .rd_en   (rd_en),
      .wr_gray (wr_gray),
      .rd_addr (rd_addr),
      .rd_gray (rd_gray),
      .empty   (empty)
   );

   fifo_mem #(.DEPTH(DEPTH)) u_mem (
      .clk_in  (clk_in),
      .wr_en   (mem_wr),
      .wr_addr (wr_addr),
      .din     (din),
      .clk_out (clk_out),
      .rd_en   (mem_rd),
      .rd_addr (rd_addr),
      .dout    (dout)
   );

endmodule

//--- fifo_cdc.sv
`timescale 1ns/100ps

module fifo_cdc #(
   parameter int DEPTH = cdc_pkg::REQ_DEPTH
) (
   // Shared asynchronous reset
   input  logic              nreset,
   // Source side
   input  logic              clk_in,
   input  logic              access_in,
   input  cdc_pkg::packet_t  packet_in,
   output logic              wait_out,
   // Destination side
   input  logic              clk_out,
   output logic              access_out,
   output cdc_pkg::packet_t  packet_out,
   input  logic              wait_in
);

   logic wr_en;
   logic rd_en;
   logic empty;

   // Sender honours wait_out within SLACK writes
   assign wr_en = access_in;

   // Pop only when the receiver can take it
   assign rd_en = ~empty & ~wait_in;

   // Valid follows the registered read data
   // Held under back-pressure until accepted
   always_ff @(posedge clk_out or negedge nreset) begin
      if (!nreset) begin
         access_out <= 1'b0;
      end else if (!wait_in) begin
         access_out <= rd_en;
      end
   end

   fifo_async #(.DEPTH(DEPTH)) u_fifo (
      .clk_in    (clk_in),
      .clk_out   (clk_out),
      .nreset    (nreset),
      .wr_en     (wr_en),
      .din       (packet_in),
      .rd_en     (rd_en),
      .dout      (packet_out),
      .empty     (empty),
      .prog_full (wait_out)
   );

endmodule

//--- fifo_mem.sv
`timescale 1ns/100ps

module fifo_mem #(
   parameter int DEPTH = cdc_pkg::REQ_DEPTH
) (
   input  logic                       clk_in,
   input  logic                       wr_en,
   input  logic [$clog2(DEPTH)-1:0]   wr_addr,
   input  cdc_pkg::packet_t           din,
   input  logic                       clk_out,
   input  logic                       rd_en,
   input  logic [$clog2(DEPTH)-1:0]   rd_addr,
   output cdc_pkg::packet_t           dout
);

   // Storage array, flat packet bits
   logic [cdc_pkg::PACKET_W-1:0] mem [DEPTH];

   // Write port in the source domain
   always_ff @(posedge clk_in) begin
      if (wr_en) begin
         mem[wr_addr] <= din;
      end
   end

   // Registered read port, output holds when idle
   always_ff @(posedge clk_out) begin
      if (rd_en) begin
         dout <= mem[rd_addr];
      end
   end

endmodule

//--- fifo_rd_ctrl.sv
`timescale 1ns/100ps

module fifo_rd_ctrl #(
   parameter int DEPTH = cdc_pkg::REQ_DEPTH
) (
   input  logic                       clk_out,
   input  logic                       nreset,
   input  logic                       rd_en,
   input  logic [$clog2(DEPTH):0]     wr_gray,
   output logic [$clog2(DEPTH)-1:0]   rd_addr,
   output logic [$clog2(DEPTH):0]     rd_gray,
   output logic                       empty
);

   localparam int AW = $clog2(DEPTH);
   // Pointer with wrap bit
   localparam int PW = AW + 1;

   logic [PW-1:0] rd_bin;
   logic [PW-1:0] rd_bin_next;
   logic [PW-1:0] wr_sync [cdc_pkg::SYNC_STAGES];
   logic          rd_ok;

   // No reads past the last written entry
   assign rd_ok       = rd_en & ~empty;
   assign rd_bin_next = rd_bin + PW'(rd_ok);
   assign rd_addr     = rd_bin[AW-1:0];

   // Read pointer, binary for addressing and Gray for crossing
   always_ff @(posedge clk_out or negedge nreset) begin
      if (!nreset) begin
         rd_bin  <= '0;
         rd_gray <= '0;
      end else begin
         rd_bin  <= rd_bin_next;
         rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
      end
   end

   // Write pointer into read domain
   always_ff @(posedge clk_out or negedge nreset) begin
      if (!nreset) begin
         for (int i = 0; i < cdc_pkg::SYNC_STAGES; i++) begin
            wr_sync[i] <= '0;
         end
      end else begin
         wr_sync[0] <= wr_gray;
         for (int i = 1; i < cdc_pkg::SYNC_STAGES; i++) begin
            wr_sync[i] <= wr_sync[i-1];
         end
      end
   end

   // Equal Gray codes, same lap, nothing to read
   assign empty = (rd_gray == wr_sync[cdc_pkg::SYNC_STAGES-1]);

endmodule

//--- fifo_wr_ctrl.sv
`timescale 1ns/100ps

module fifo_wr_ctrl #(
   parameter int DEPTH = cdc_pkg::REQ_DEPTH
) (
   input  logic                       clk_in,
   input  logic                       nreset,
   input  logic                       wr_en,
   input  logic [$clog2(DEPTH):0]     rd_gray,
   output logic [$clog2(DEPTH)-1:0]   wr_addr,
   output logic [$clog2(DEPTH):0]     wr_gray,
   output logic                       full,
   output logic                       prog_full
);

   localparam int AW = $clog2(DEPTH);
   // Extra MSB tells wrap laps apart
   localparam int PW = AW + 1;
   localparam logic [PW-1:0] PF_LEVEL = PW'(DEPTH - cdc_pkg::SLACK);

   logic [PW-1:0] wr_bin;
   logic [PW-1:0] wr_bin_next;
   logic [PW-1:0] rd_sync [cdc_pkg::SYNC_STAGES];
   logic [PW-1:0] rd_bin;
   logic [PW-1:0] fill;
   logic          wr_ok;

   function automatic logic [PW-1:0] gray2bin(input logic [PW-1:0] g);
      logic [PW-1:0] b;
      b[PW-1] = g[PW-1];
      for (int i = PW - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // Drop writes once full
   assign wr_ok       = wr_en & ~full;
   assign wr_bin_next = wr_bin + PW'(wr_ok);
   assign wr_addr     = wr_bin[AW-1:0];

   // Binary and Gray pointers advance together
   always_ff @(posedge clk_in or negedge nreset) begin
      if (!nreset) begin
         wr_bin  <= '0;
         wr_gray <= '0;
      end else begin
         wr_bin  <= wr_bin_next;
         wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
      end
   end

   // Read pointer into write domain
   always_ff @(posedge clk_in or negedge nreset) begin
      if (!nreset) begin
         for (int i = 0; i < cdc_pkg::SYNC_STAGES; i++) begin
            rd_sync[i] <= '0;
         end
      end else begin
         rd_sync[0] <= rd_gray;
         for (int i = 1; i < cdc_pkg::SYNC_STAGES; i++) begin
            rd_sync[i] <= rd_sync[i-1];
         end
      end
   end

   // Fill count, pessimistic by the sync delay
   assign rd_bin = gray2bin(rd_sync[cdc_pkg::SYNC_STAGES-1]);
   assign fill   = wr_bin - rd_bin;
   assign full   = (fill == PW'(DEPTH));

   // Almost full, one edge behind the pointer
   always_ff @(posedge clk_in or negedge nreset) begin
      if (!nreset) begin
         prog_full <= 1'b0;
      end else begin
         prog_full <= (fill >= PF_LEVEL);
      end
   end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the CDC bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cdc_bridge \
   -f all.f -o tb_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/tb_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^TEST OK$"; then
   exit 0
fi
exit 1

//--- tb_cdc_bridge.sv
`timescale 1ns/100ps

module tb_cdc_bridge;

   logic             nreset;
   logic             clk_in;
   logic             clk_out;
   logic             req_access_in;
   cdc_pkg::packet_t req_packet_in;
   logic             req_wait_out;
   logic             req_access_out;
   cdc_pkg::packet_t req_packet_out;
   logic             req_wait_in;
   logic             rsp_access_in;
   cdc_pkg::packet_t rsp_packet_in;
   logic             rsp_wait_out;
   logic             rsp_access_out;
   cdc_pkg::packet_t rsp_packet_out;
   logic             rsp_wait_in;

   // Traffic bookkeeping, index counters per direction
   int               req_sent;
   int               req_rcv;
   int               req_limit;
   int               req_stall;
   int               rsp_sent;
   int               rsp_rcv;
   int               rsp_limit;
   int               rsp_stall;
   bit               traffic_on;
   bit               req_pause_en;
   bit               req_hold;
   bit               req_held;
   bit               rsp_held;
   cdc_pkg::packet_t req_held_pkt;
   cdc_pkg::packet_t rsp_held_pkt;
   int               accepted;

   cdc_bridge uut (.*);

   // Source clock, 14 ns
   initial begin
      clk_in = 1'b0;
      forever #7 clk_in = ~clk_in;
   end

   // Destination clock, 20 ns
   initial begin
      clk_out = 1'b0;
      forever #10 clk_out = ~clk_out;
   end

   // Deterministic packet per index, dir 0 for requests and 1 for responses
   function automatic cdc_pkg::packet_t expected_packet(input int index, input bit dir);
      logic [31:0]      i;
      cdc_pkg::packet_t p;
      i          = 32'(index);
      p.write    = i[0] ^ dir;
      p.datamode = cdc_pkg::datamode_t'(i[1:0]);
      p.ctrlmode = i[6:2] ^ {dir, 4'b0101};
      p.dstaddr  = {4'h8 ^ {dir, 3'b000}, i[25:0], 2'b00};
      p.data     = (i * 32'h9e37_79b1) + 32'(dir);
      p.srcaddr  = {(dir ? 16'hb0b0 : 16'ha0a0), i[15:0]};
      return p;
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "run aborted");
   endtask

   task automatic check_packet(input string name, input cdc_pkg::packet_t act,
                               input cdc_pkg::packet_t exp);
      if (act !== exp) begin
         abort_run($sformatf("mismatch %s: got %h expected %h", name, act, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic act, input logic exp);
      if (act !== exp) begin
         abort_run($sformatf("mismatch %s: got %h expected %h", name, act, exp));
      end
   endtask

   task automatic check_reset_outputs();
      check_flag("req_access_out", req_access_out, 1'b0);
      check_flag("rsp_access_out", rsp_access_out, 1'b0);
      check_flag("req_wait_out", req_wait_out, 1'b0);
      check_flag("rsp_wait_out", rsp_wait_out, 1'b0);
   endtask

   // Request sender, a write lands on each edge with access high
   always @(posedge clk_in) begin
      if (traffic_on) begin
         if (req_access_in) req_sent = req_sent + 1;
         if (req_sent < req_limit && !req_wait_out &&
             !(req_pause_en && $urandom_range(0, 3) == 0)) begin
            req_access_in <= 1'b1;
            req_packet_in <= expected_packet(req_sent, 1'b0);
         end else begin
            req_access_in <= 1'b0;
         end
      end
   end

   // Response sender on the other clock
   always @(posedge clk_out) begin
      if (traffic_on) begin
         if (rsp_access_in) rsp_sent = rsp_sent + 1;
         if (rsp_sent < rsp_limit && !rsp_wait_out && $urandom_range(0, 3) != 0) begin
            rsp_access_in <= 1'b1;
            rsp_packet_in <= expected_packet(rsp_sent, 1'b1);
         end else begin
            rsp_access_in <= 1'b0;
         end
      end
   end

   // Request receiver and compare
   always @(posedge clk_out) begin
      if (traffic_on) begin
         // Output must not move while stalled
         if (req_held) begin
            check_flag("req_access_out", req_access_out, 1'b1);
            check_packet("req_packet_out", req_packet_out, req_held_pkt);
         end
         if (req_access_out && !req_wait_in) begin
            check_packet("req_packet_out", req_packet_out, expected_packet(req_rcv, 1'b0));
            req_rcv = req_rcv + 1;
         end
         req_held     = req_access_out && req_wait_in;
         req_held_pkt = req_packet_out;
         // Stall bursts
         if (req_hold) begin
            req_wait_in <= 1'b1;
         end else if (req_stall > 0) begin
            req_stall = req_stall - 1;
            req_wait_in <= 1'b1;
         end else if ($urandom_range(0, 19) == 0) begin
            req_stall = $urandom_range(4, 40);
            req_wait_in <= 1'b1;
         end else begin
            req_wait_in <= 1'b0;
         end
      end
   end

   // Response receiver and compare
   always @(posedge clk_in) begin
      if (traffic_on) begin
         if (rsp_held) begin
            check_flag("rsp_access_out", rsp_access_out, 1'b1);
            check_packet("rsp_packet_out", rsp_packet_out, rsp_held_pkt);
         end
         if (rsp_access_out && !rsp_wait_in) begin
            check_packet("rsp_packet_out", rsp_packet_out, expected_packet(rsp_rcv, 1'b1));
            rsp_rcv = rsp_rcv + 1;
         end
         rsp_held     = rsp_access_out && rsp_wait_in;
         rsp_held_pkt = rsp_packet_out;
         if (rsp_stall > 0) begin
            rsp_stall = rsp_stall - 1;
            rsp_wait_in <= 1'b1;
         end else if ($urandom_range(0, 19) == 0) begin
            rsp_stall = $urandom_range(4, 40);
            rsp_wait_in <= 1'b1;
         end else begin
            rsp_wait_in <= 1'b0;
         end
      end
   end

   initial begin
      int t;
      void'($urandom(32'h5b8efc35));
      nreset        = 1'b0;
      req_access_in = 1'b0;
      req_packet_in = '0;
      req_wait_in   = 1'b0;
      rsp_access_in = 1'b0;
      rsp_packet_in = '0;
      rsp_wait_in   = 1'b0;
      traffic_on    = 1'b0;
      req_pause_en  = 1'b1;
      req_hold      = 1'b0;
      req_limit     = 300;
      rsp_limit     = 300;

      // Reset held for 16 cycles, outputs idle throughout
      repeat (16) begin
         @(posedge clk_out);
         check_reset_outputs();
      end
      nreset <= 1'b1;
      @(posedge clk_out);
      check_reset_outputs();
      @(negedge clk_out);
      traffic_on = 1'b1;

      // Random traffic both ways
      t = 0;
      while (req_rcv < 300 || rsp_rcv < 300) begin
         @(negedge clk_out);
         t++;
         if (t > 100000) abort_run("timeout: 300 requests and 300 responses never arrived");
      end

      // Fill the request FIFO with the receiver stalled
      req_hold     = 1'b1;
      req_pause_en = 1'b0;
      req_limit    = 340;
      t = 0;
      while (!req_wait_out) begin
         @(negedge clk_in);
         t++;
         if (t > 500) abort_run("timeout: req_wait_out never rose with the receiver stalled");
      end
      repeat (8) @(negedge clk_in);
      accepted = req_sent - 300;
      if (accepted < cdc_pkg::REQ_DEPTH - cdc_pkg::SLACK || accepted > cdc_pkg::REQ_DEPTH) begin
         abort_run($sformatf("mismatch accepted_writes: got %h expected %h..%h", accepted,
                             cdc_pkg::REQ_DEPTH - cdc_pkg::SLACK, cdc_pkg::REQ_DEPTH));
      end

      // Release and drain the rest
      req_hold = 1'b0;
      t = 0;
      while (req_rcv < 340) begin
         @(negedge clk_out);
         t++;
         if (t > 20000) abort_run("timeout: requests after the stall never all arrived");
      end
      repeat (100) @(negedge clk_out);
      if (req_rcv != 340 || rsp_rcv != 300) begin
         abort_run("extra transfers arrived after all packets were received");
      end else begin
         $display("TEST OK");
         $finish;
      end
   end

endmodule
